// File: include/nasti_macros.svh
// NASTI bus and memory sizes
`ifndef NASTI_MACROS_SVH
`define NASTI_MACROS_SVH

// transaction id width
`define NASTI_ID_WIDTH 4

// byte address width
`define NASTI_ADDR_WIDTH 16

// one data beat at full width
`define NASTI_DATA_WIDTH 32

// burst length field holding beats minus one
`define NASTI_LEN_WIDTH 4

// RAM depth in data words
`define NASTI_MEM_WORDS 256

// default channel FIFO depth
`define NASTI_FIFO_DEPTH 4

`endif

// File: nasti_mem_sys.f
+incdir+include
src/nasti_pkg.sv
src/nasti_chan_fifo.sv
src/nasti_burst_master.sv
src/nasti_ram.sv
src/nasti_mem_sys.sv
testbench/nasti_mem_sys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the NASTI memory subsystem testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
   -f nasti_mem_sys.f \
   --top-module nasti_mem_sys_tb \
   --Mdir obj_dir -o nasti_mem_sys_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/nasti_mem_sys_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "All checks passed"; then
   exit 0
fi
echo "Simulation did not report a pass"
exit 1

// File: src/nasti_burst_master.sv
// NASTI burst master
`timescale 1ns/1ps

module nasti_burst_master (
   input  logic                   clk,
   input  logic                   rstn,
   input  nasti_pkg::host_cmd_t   cmd,
   input  logic                   cmd_valid,
   output logic                   cmd_ready,
   input  nasti_pkg::host_wdata_t wdata,
   input  logic                   wdata_valid,
   output logic                   wdata_ready,
   output nasti_pkg::nasti_addr_t aw,
   output logic                   aw_valid,
   input  logic                   aw_ready,
   output nasti_pkg::nasti_addr_t ar,
   output logic                   ar_valid,
   input  logic                   ar_ready,
   output nasti_pkg::nasti_w_t    w,
   output logic                   w_valid,
   input  logic                   w_ready
);

   import nasti_pkg::*;

   master_state_t state;
   len_t          beat_cnt;
   logic          aw_hs;
   logic          w_hs;

   // both address channels see the command but only one gets valid
   assign aw = cmd.addr;
   assign ar = cmd.addr;

   assign ar_valid = cmd_valid && !cmd.write;
   // new write waits until previous burst data is out
   assign aw_valid = cmd_valid && cmd.write && (state == MST_IDLE);

   assign cmd_ready = cmd.write ? ((state == MST_IDLE) && aw_ready) : ar_ready;

   // write data passes straight through while a burst is open
   assign w.data      = wdata.data;
   assign w.strb      = wdata.strb;
   assign w.last      = (beat_cnt == '0);
   assign w_valid     = (state == MST_SEND_W) && wdata_valid;
   assign wdata_ready = (state == MST_SEND_W) && w_ready;

   assign aw_hs = aw_valid && aw_ready;
   assign w_hs  = w_valid && w_ready;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state    <= MST_IDLE;
         beat_cnt <= '0;
      end else begin
         case (state)
            MST_IDLE: begin
               if (aw_hs) begin
                  state    <= MST_SEND_W;
                  beat_cnt <= cmd.addr.len;
               end
            end
            MST_SEND_W: begin
               if (w_hs) begin
                  if (beat_cnt == '0) begin
                     state <= MST_IDLE;
                  end else begin
                     beat_cnt <= beat_cnt - 1'b1;
                  end
               end
            end
            default: state <= MST_IDLE;
         endcase
      end
   end

endmodule

// File: src/nasti_chan_fifo.sv
// valid/ready channel FIFO
`timescale 1ns/1ps
`include "nasti_macros.svh"

module nasti_chan_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = `NASTI_FIFO_DEPTH
) (
   input  logic             clk,
   input  logic             rstn,
   input  logic [WIDTH-1:0] in_data,
   input  logic             in_valid,
   output logic             in_ready,
   output logic [WIDTH-1:0] out_data,
   output logic             out_valid,
   input  logic             out_ready
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [0:DEPTH-1];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] count_next;
   logic             push;
   logic             pop;

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];

   always_comb begin
      count_next = count;
      if (push && !pop) begin
         count_next = count + 1'b1;
      end else if (pop && !push) begin
         count_next = count - 1'b1;
      end
   end

   // in_ready low during reset and while full
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         in_ready <= 1'b0;
      end else begin
         count    <= count_next;
         in_ready <= (count_next != CNT_W'(DEPTH));
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

endmodule

// File: src/nasti_mem_sys.sv
// NASTI memory subsystem top
`timescale 1ns/1ps

module nasti_mem_sys (
   input  logic                   clk,
   input  logic                   rstn,
   input  nasti_pkg::host_cmd_t   cmd,
   input  logic                   cmd_valid,
   output logic                   cmd_ready,
   input  nasti_pkg::host_wdata_t wdata,
   input  logic                   wdata_valid,
   output logic                   wdata_ready,
   output nasti_pkg::nasti_b_t    b,
   output logic                   b_valid,
   input  logic                   b_ready,
   output nasti_pkg::nasti_r_t    r,
   output logic                   r_valid,
   input  logic                   r_ready
);

   import nasti_pkg::*;

   // master side of the FIFOs
   nasti_addr_t m_aw;
   logic        m_aw_valid;
   logic        m_aw_ready;
   nasti_addr_t m_ar;
   logic        m_ar_valid;
   logic        m_ar_ready;
   nasti_w_t    m_w;
   logic        m_w_valid;
   logic        m_w_ready;

   // RAM side of the FIFOs
   nasti_addr_t s_aw;
   logic        s_aw_valid;
   logic        s_aw_ready;
   nasti_addr_t s_ar;
   logic        s_ar_valid;
   logic        s_ar_ready;
   nasti_w_t    s_w;
   logic        s_w_valid;
   logic        s_w_ready;

   nasti_burst_master u_master (
      .clk         (clk),
      .rstn        (rstn),
      .cmd         (cmd),
      .cmd_valid   (cmd_valid),
      .cmd_ready   (cmd_ready),
      .wdata       (wdata),
      .wdata_valid (wdata_valid),
      .wdata_ready (wdata_ready),
      .aw          (m_aw),
      .aw_valid    (m_aw_valid),
      .aw_ready    (m_aw_ready),
      .ar          (m_ar),
      .ar_valid    (m_ar_valid),
      .ar_ready    (m_ar_ready),
      .w           (m_w),
      .w_valid     (m_w_valid),
      .w_ready     (m_w_ready)
   );

   nasti_chan_fifo #(.WIDTH($bits(nasti_addr_t))) u_aw_fifo (
      .clk       (clk),
      .rstn      (rstn),
      .in_data   (m_aw),
      .in_valid  (m_aw_valid),
      .in_ready  (m_aw_ready),
      .out_data  (s_aw),
      .out_valid (s_aw_valid),
      .out_ready (s_aw_ready)
   );

   nasti_chan_fifo #(.WIDTH($bits(nasti_w_t))) u_w_fifo (
      .clk       (clk),
      .rstn      (rstn),
      .in_data   (m_w),
      .in_valid  (m_w_valid),
      .in_ready  (m_w_ready),
      .out_data  (s_w),
      .out_valid (s_w_valid),
      .out_ready (s_w_ready)
   );

   nasti_chan_fifo #(.WIDTH($bits(nasti_addr_t))) u_ar_fifo (
      .clk       (clk),
      .rstn      (rstn),
      .in_data   (m_ar),
      .in_valid  (m_ar_valid),
      .in_ready  (m_ar_ready),
      .out_data  (s_ar),
      .out_valid (s_ar_valid),
      .out_ready (s_ar_ready)
   );

   nasti_ram u_ram (
      .clk      (clk),
      .rstn     (rstn),
      .aw       (s_aw),
      .aw_valid (s_aw_valid),
      .aw_ready (s_aw_ready),
      .w        (s_w),
      .w_valid  (s_w_valid),
      .w_ready  (s_w_ready),
      .ar       (s_ar),
      .ar_valid (s_ar_valid),
      .ar_ready (s_ar_ready),
      .b        (b),
      .b_valid  (b_valid),
      .b_ready  (b_ready),
      .r        (r),
      .r_valid  (r_valid),
      .r_ready  (r_ready)
   );

endmodule

// File: src/nasti_pkg.sv
// NASTI types and channel structs
`include "nasti_macros.svh"

package nasti_pkg;

   typedef logic [`NASTI_ID_WIDTH-1:0]     id_t;
   typedef logic [`NASTI_ADDR_WIDTH-1:0]   addr_t;
   typedef logic [`NASTI_DATA_WIDTH-1:0]   data_t;
   typedef logic [`NASTI_DATA_WIDTH/8-1:0] strb_t;
   typedef logic [`NASTI_LEN_WIDTH-1:0]    len_t;
   typedef logic [1:0]                     resp_t;

   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

   // shared by AW and AR
   typedef struct packed {
      id_t   id;
      addr_t addr;
      len_t  len;
   } nasti_addr_t;

   typedef struct packed {
      data_t data;
      strb_t strb;
      logic  last;
   } nasti_w_t;

   typedef struct packed {
      id_t   id;
      resp_t resp;
   } nasti_b_t;

   typedef struct packed {
      id_t   id;
      data_t data;
      resp_t resp;
      logic  last;
   } nasti_r_t;

   // host command whose write flag selects AW or AR
   typedef struct packed {
      logic        write;
      nasti_addr_t addr;
   } host_cmd_t;

   typedef struct packed {
      data_t data;
      strb_t strb;
   } host_wdata_t;

   typedef enum logic [0:0] {
      MST_IDLE,
      MST_SEND_W
   } master_state_t;

   typedef enum logic [1:0] {
      RAM_IDLE,
      RAM_WRITE,
      RAM_WRESP,
      RAM_READ
   } ram_state_t;

endpackage

// File: src/nasti_ram.sv
// NASTI RAM slave
`timescale 1ns/1ps
`include "nasti_macros.svh"

module nasti_ram (
   input  logic                   clk,
   input  logic                   rstn,
   input  nasti_pkg::nasti_addr_t aw,
   input  logic                   aw_valid,
   output logic                   aw_ready,
   input  nasti_pkg::nasti_w_t    w,
   input  logic                   w_valid,
   output logic                   w_ready,
   input  nasti_pkg::nasti_addr_t ar,
   input  logic                   ar_valid,
   output logic                   ar_ready,
   output nasti_pkg::nasti_b_t    b,
   output logic                   b_valid,
   input  logic                   b_ready,
   output nasti_pkg::nasti_r_t    r,
   output logic                   r_valid,
   input  logic                   r_ready
);

   import nasti_pkg::*;

   localparam int NBYTES     = `NASTI_DATA_WIDTH / 8;
   localparam int WORD_SHIFT = $clog2(NBYTES);
   localparam int IDX_W      = $clog2(`NASTI_MEM_WORDS);
   localparam int END_W      = `NASTI_ADDR_WIDTH + 1;

   data_t       mem [0:`NASTI_MEM_WORDS-1];
   ram_state_t  state;
   id_t         id_q;
   logic [IDX_W-1:0] word_q;
   len_t        beats_q;
   logic        err_q;
   nasti_addr_t a_sel;
   logic        aw_hs;
   logic        ar_hs;
   logic        w_hs;
   logic        b_hs;
   logic        r_hs;

   // burst is out of range when its final word is past the array
   function automatic logic burst_err(input nasti_addr_t a);
      logic [END_W-1:0] end_word;
      end_word = END_W'(a.addr >> WORD_SHIFT) + END_W'(a.len);
      return end_word >= END_W'(`NASTI_MEM_WORDS);
   endfunction

   // AW wins over AR and a ready only rises with a pending valid
   assign aw_ready = (state == RAM_IDLE) && aw_valid;
   assign ar_ready = (state == RAM_IDLE) && !aw_valid && ar_valid;
   assign w_ready  = (state == RAM_WRITE);
   assign b_valid  = (state == RAM_WRESP);
   assign r_valid  = (state == RAM_READ);

   assign aw_hs = aw_valid && aw_ready;
   assign ar_hs = ar_valid && ar_ready;
   assign w_hs  = w_valid && w_ready;
   assign b_hs  = b_valid && b_ready;
   assign r_hs  = r_valid && r_ready;

   assign a_sel = aw_hs ? aw : ar;

   assign b.id   = id_q;
   assign b.resp = err_q ? RESP_SLVERR : RESP_OKAY;

   // error beats read as zero
   assign r.id   = id_q;
   assign r.data = err_q ? '0 : mem[word_q];
   assign r.resp = err_q ? RESP_SLVERR : RESP_OKAY;
   assign r.last = (beats_q == '0);

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state   <= RAM_IDLE;
         id_q    <= '0;
         word_q  <= '0;
         beats_q <= '0;
         err_q   <= 1'b0;
      end else begin
         case (state)
            RAM_IDLE: begin
               if (aw_hs || ar_hs) begin
                  state   <= aw_hs ? RAM_WRITE : RAM_READ;
                  id_q    <= a_sel.id;
                  word_q  <= IDX_W'(a_sel.addr >> WORD_SHIFT);
                  beats_q <= a_sel.len;
                  err_q   <= burst_err(a_sel);
               end
            end
            RAM_WRITE: begin
               if (w_hs) begin
                  if (w.last || beats_q == '0) begin
                     state <= RAM_WRESP;
                  end else begin
                     word_q  <= word_q + 1'b1;
                     beats_q <= beats_q - 1'b1;
                  end
               end
            end
            RAM_WRESP: begin
               if (b_hs) begin
                  state <= RAM_IDLE;
               end
            end
            RAM_READ: begin
               if (r_hs) begin
                  if (beats_q == '0) begin
                     state <= RAM_IDLE;
                  end else begin
                     word_q  <= word_q + 1'b1;
                     beats_q <= beats_q - 1'b1;
                  end
               end
            end
            default: state <= RAM_IDLE;
         endcase
      end
   end

   // byte-masked write that is dropped for an errored burst
   always_ff @(posedge clk) begin
      if (w_hs && !err_q) begin
         for (int i = 0; i < NBYTES; i++) begin
            if (w.strb[i]) begin
               mem[word_q][8*i +: 8] <= w.data[8*i +: 8];
            end
         end
      end
   end

endmodule

// File: testbench/nasti_mem_sys_tb.sv
// NASTI memory subsystem testbench
`timescale 1ns/1ps
`include "nasti_macros.svh"

module nasti_mem_sys_tb;

   import nasti_pkg::*;

   localparam int MEM_WORDS = `NASTI_MEM_WORDS;
   localparam int TIMEOUT   = 2000;
   localparam int FILL      = 0;
   localparam int FULL      = 1;
   localparam int PARTIAL   = 2;

   logic        clk;
   logic        rstn;
   host_cmd_t   cmd;
   logic        cmd_valid;
   logic        cmd_ready;
   host_wdata_t wdata;
   logic        wdata_valid;
   logic        wdata_ready;
   nasti_b_t    b;
   logic        b_valid;
   logic        b_ready;
   nasti_r_t    r;
   logic        r_valid;
   logic        r_ready;

   integer      seed;
   data_t       model [0:MEM_WORDS-1];
   logic [3:0]  ready_pat [0:127];
   logic        stall_en;
   logic        gaps_en;
   nasti_b_t    exp_b [$];
   nasti_r_t    exp_r [$];
   int          b_issued;
   int          r_issued;
   int          b_seen;
   int          r_seen;
   int          mismatches;
   int          other_errors;

   nasti_mem_sys UUT (
      .clk         (clk),
      .rstn        (rstn),
      .cmd         (cmd),
      .cmd_valid   (cmd_valid),
      .cmd_ready   (cmd_ready),
      .wdata       (wdata),
      .wdata_valid (wdata_valid),
      .wdata_ready (wdata_ready),
      .b           (b),
      .b_valid     (b_valid),
      .b_ready     (b_ready),
      .r           (r),
      .r_valid     (r_valid),
      .r_ready     (r_ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // start word plus length must stay inside the array
   function automatic logic in_range(input addr_t addr, input len_t len);
      return (int'(addr) / 4 + int'(len)) < MEM_WORDS;
   endfunction

   function automatic nasti_b_t expected_b(input id_t id, input addr_t addr, input len_t len);
      nasti_b_t e;
      e.id   = id;
      e.resp = in_range(addr, len) ? RESP_OKAY : RESP_SLVERR;
      return e;
   endfunction

   function automatic nasti_r_t expected_r(input id_t id, input addr_t addr, input len_t len,
                                           input int beat);
      nasti_r_t e;
      e.id   = id;
      e.last = (beat == int'(len));
      if (in_range(addr, len)) begin
         e.data = model[int'(addr) / 4 + beat];
         e.resp = RESP_OKAY;
      end else begin
         e.data = '0;
         e.resp = RESP_SLVERR;
      end
      return e;
   endfunction

   function automatic data_t merge_bytes(input data_t old_d, input data_t new_d, input strb_t s);
      data_t res;
      res = old_d;
      for (int i = 0; i < $bits(strb_t); i++) begin
         if (s[i]) begin
            res[i*8 +: 8] = new_d[i*8 +: 8];
         end
      end
      return res;
   endfunction

   // preload pattern built from the full byte address
   function automatic data_t fill_word(input int unsigned word);
      addr_t a;
      a = addr_t'(word * 4);
      return {a ^ 16'h5a5a, ~a};
   endfunction

   task automatic check_b(input nasti_b_t got, input nasti_b_t exp);
      if (got !== exp) begin
         $display("Mismatch b: got id=%h resp=%h, expected id=%h resp=%h",
                  got.id, got.resp, exp.id, exp.resp);
         mismatches++;
      end
   endtask

   task automatic check_r(input nasti_r_t got, input nasti_r_t exp);
      if (got !== exp) begin
         $display("Mismatch r: id=%h/%h data=%h/%h resp=%h/%h last=%h/%h (got/expected)",
                  got.id, exp.id, got.data, exp.data, got.resp, exp.resp, got.last, exp.last);
         mismatches++;
      end
   endtask

   task automatic finish_run();
      $display("Error counts: %0d mismatches, %0d other errors", mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   endtask

   task automatic timed_out(input string what);
      $display("Timeout while waiting for %s", what);
      other_errors++;
      finish_run();
   endtask

   // random stalls on the response readies
   initial begin : ready_drive
      int k;
      k = 0;
      b_ready = 1'b0;
      r_ready = 1'b0;
      forever begin
         @(negedge clk);
         if (stall_en) begin
            b_ready = |ready_pat[k][3:2];
            r_ready = |ready_pat[k][1:0];
            k = (k + 1) % 128;
         end else begin
            b_ready = 1'b1;
            r_ready = 1'b1;
         end
      end
   end

   // response monitor that checks in issue order
   initial begin : compare
      nasti_b_t eb;
      nasti_r_t er;
      forever begin
         @(posedge clk);
         if (rstn && b_valid && b_ready) begin
            if (exp_b.size() == 0) begin
               $display("Error: a B response arrived with no write outstanding");
               other_errors++;
            end else begin
               eb = exp_b.pop_front();
               check_b(b, eb);
            end
            b_seen++;
         end
         if (rstn && r_valid && r_ready) begin
            if (exp_r.size() == 0) begin
               $display("Error: an R beat arrived with no read outstanding");
               other_errors++;
            end else begin
               er = exp_r.pop_front();
               check_r(r, er);
            end
            r_seen++;
         end
      end
   end

   task automatic send_cmd(input logic write, input id_t id, input addr_t addr, input len_t len);
      int   cycles;
      logic taken;
      cycles = 0;
      taken  = 1'b0;
      @(negedge clk);
      cmd.write     = write;
      cmd.addr.id   = id;
      cmd.addr.addr = addr;
      cmd.addr.len  = len;
      cmd_valid     = 1'b1;
      while (!taken) begin
         @(posedge clk);
         taken = cmd_ready;
         cycles++;
         if (!taken && cycles >= TIMEOUT) begin
            timed_out("the host command to be accepted");
         end
      end
   endtask

   task automatic send_wbeat(input data_t d, input strb_t s, input int gap);
      int   cycles;
      logic taken;
      cycles = 0;
      taken  = 1'b0;
      @(negedge clk);
      cmd_valid   = 1'b0;
      wdata_valid = 1'b0;
      repeat (gap) @(negedge clk);
      wdata.data  = d;
      wdata.strb  = s;
      wdata_valid = 1'b1;
      while (!taken) begin
         @(posedge clk);
         taken = wdata_ready;
         cycles++;
         if (!taken && cycles >= TIMEOUT) begin
            timed_out("a host write beat to be accepted");
         end
      end
   endtask

   // drop the host valids and let every response drain
   task automatic wait_idle();
      int cycles;
      cycles = 0;
      @(negedge clk);
      cmd_valid   = 1'b0;
      wdata_valid = 1'b0;
      while (b_seen < b_issued || r_seen < r_issued) begin
         @(negedge clk);
         cycles++;
         if (cycles >= TIMEOUT) begin
            timed_out("outstanding B and R responses");
         end
      end
   endtask

   task automatic write_burst(input id_t id, input int unsigned word, input len_t len,
                              input int mode);
      addr_t addr;
      data_t d;
      strb_t s;
      logic  ok;
      int    gap;
      addr = addr_t'(word * 4);
      wait_idle();
      ok = in_range(addr, len);
      exp_b.push_back(expected_b(id, addr, len));
      b_issued++;
      send_cmd(1'b1, id, addr, len);
      for (int i = 0; i <= int'(len); i++) begin
         if (mode == FILL) begin
            d = fill_word(word + i);
            s = '1;
         end else begin
            d = $random(seed);
            s = (mode == PARTIAL) ? strb_t'($random(seed)) : '1;
         end
         gap = gaps_en ? int'({$random(seed)} % 3) : 0;
         // out of range writes leave the model alone
         if (ok) begin
            model[word + i] = merge_bytes(model[word + i], d, s);
         end
         send_wbeat(d, s, gap);
      end
   endtask

   task automatic read_burst(input id_t id, input int unsigned word, input len_t len);
      addr_t addr;
      addr = addr_t'(word * 4);
      for (int i = 0; i <= int'(len); i++) begin
         exp_r.push_back(expected_r(id, addr, len, i));
      end
      r_issued += int'(len) + 1;
      send_cmd(1'b0, id, addr, len);
   endtask

   task automatic random_burst(input int mode);
      id_t         id;
      len_t        len;
      int unsigned word;
      id   = id_t'($random(seed));
      len  = len_t'($random(seed));
      word = {$random(seed)} % (MEM_WORDS - int'(len));
      write_burst(id, word, len, mode);
      wait_idle();
      read_burst(id + 1'b1, word, len);
   endtask

   initial begin : main
      int unsigned word;
      seed         = 32'h820f4526;
      rstn         = 1'b0;
      cmd          = '0;
      cmd_valid    = 1'b0;
      wdata        = '0;
      wdata_valid  = 1'b0;
      stall_en     = 1'b0;
      gaps_en      = 1'b0;
      b_issued     = 0;
      r_issued     = 0;
      b_seen       = 0;
      r_seen       = 0;
      mismatches   = 0;
      other_errors = 0;
      for (int i = 0; i < 128; i++) begin
         ready_pat[i] = 4'($random(seed));
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;

      // preload every word so the model is fully known
      for (int i = 0; i < MEM_WORDS / 16; i++) begin
         write_burst(id_t'(i), i * 16, 4'hf, FILL);
      end

      for (int i = 0; i < 8; i++) begin
         word = {$random(seed)} % MEM_WORDS;
         write_burst(id_t'(i), word, '0, FULL);
         wait_idle();
         read_burst(id_t'(i + 8), word, '0);
      end

      for (int i = 0; i < 12; i++) begin
         random_burst(FULL);
      end
      for (int i = 0; i < 8; i++) begin
         random_burst(PARTIAL);
      end

      // bursts past the end of the array and reads of the words they would hit
      write_burst(4'h3, MEM_WORDS - 6, 4'h9, FULL);
      wait_idle();
      read_burst(4'h4, MEM_WORDS - 6, 4'h9);
      write_burst(4'h5, MEM_WORDS + 44, '0, FULL);
      wait_idle();
      read_burst(4'h6, MEM_WORDS + 44, '0);
      wait_idle();
      read_burst(4'h7, MEM_WORDS - 16, 4'hf);
      wait_idle();
      read_burst(4'h8, (MEM_WORDS + 44) % MEM_WORDS, '0);

      stall_en = 1'b1;
      gaps_en  = 1'b1;
      for (int i = 0; i < 12; i++) begin
         random_burst(PARTIAL);
      end

      // reads queued back to back
      wait_idle();
      for (int i = 0; i < 6; i++) begin
         read_burst(id_t'(i + 9), {$random(seed)} % (MEM_WORDS - 8), len_t'(i));
      end
      wait_idle();

      // nothing may still be pending once every response is in
      if (b_valid || r_valid) begin
         $display("Error: the DUT still holds a response after the last expected one");
         other_errors++;
      end
      finish_run();
   end

endmodule
